//--- src/isa_pkg.sv
package isa_pkg;

    // Architectural sizes
    localparam int word_width     = 32;
    localparam int reg_count      = 32;
    localparam int reg_addr_width = 5;

    // Instruction field widths and positions
    localparam int op_width    = 6;
    localparam int funct_width = 6;
    localparam int imm_width   = 16;
    localparam int rs_lsb      = 21;
    localparam int rt_lsb      = 16;
    localparam int rd_lsb      = 11;

    // Hardwired zero register
    localparam logic [reg_addr_width-1:0] reg_zero = '0;

    typedef enum logic [op_width-1:0] {
        op_special = 6'h00,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    // Function codes under op_special
    typedef enum logic [funct_width-1:0] {
        fn_mult = 6'h18,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_t;

endpackage

//--- src/issue_pkg.sv
package issue_pkg;

    // Target functional unit of an issued instruction
    typedef enum logic [1:0] {
        unit_alu  = 2'b00,
        unit_mem  = 2'b01,
        unit_mul  = 2'b10,
        unit_none = 2'b11
    } unit_t;

    // Operation handed to the ALU
    // Loads and stores use alu_add for the address sum
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4,
        alu_lui = 3'd5
    } alu_op_t;

endpackage

//--- src/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [isa_pkg::reg_addr_width-1:0] rs_addr,
    input  logic [isa_pkg::reg_addr_width-1:0] rt_addr,
    output logic [isa_pkg::word_width-1:0]     rs_data,
    output logic [isa_pkg::word_width-1:0]     rt_data,
    input  logic                               write_en,
    input  logic [isa_pkg::reg_addr_width-1:0] write_addr,
    input  logic [isa_pkg::word_width-1:0]     write_data
);

    import isa_pkg::*;

    // Register 0 has no storage
    logic [word_width-1:0] regs [1:reg_count-1];

    // Combinational reads see the value before a same-cycle write
    assign rs_data = (rs_addr == reg_zero) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == reg_zero) ? '0 : regs[rt_addr];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_addr != reg_zero) begin
            regs[write_addr] <= write_data;
        end
    end

endmodule

//--- src/scoreboard.sv
`timescale 1ns/1ps

module scoreboard (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [isa_pkg::reg_addr_width-1:0] rs_addr,
    input  logic [isa_pkg::reg_addr_width-1:0] rt_addr,
    output logic                               rs_pending,
    output logic                               rt_pending,
    input  logic                               set_en,
    input  logic [isa_pkg::reg_addr_width-1:0] set_addr,
    input  logic                               clear_en,
    input  logic [isa_pkg::reg_addr_width-1:0] clear_addr
);

    import isa_pkg::*;

    // One bit per register with an outstanding result
    logic [reg_count-1:0] pending;
    logic [reg_count-1:0] set_mask;
    logic [reg_count-1:0] clear_mask;

    // Both source lookups in the same cycle
    assign rs_pending = pending[rs_addr];
    assign rt_pending = pending[rt_addr];

    // One-hot decode of the issue and writeback strobes
    always_comb begin
        set_mask   = '0;
        clear_mask = '0;
        if (set_en) begin
            set_mask[set_addr] = 1'b1;
        end
        if (clear_en) begin
            clear_mask[clear_addr] = 1'b1;
        end
        // Register 0 never becomes pending
        set_mask[reg_zero]   = 1'b0;
        clear_mask[reg_zero] = 1'b0;
    end

    // Set is applied after clear so it wins on a collision
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clear_mask) | set_mask;
        end
    end

endmodule

//--- src/instr_classifier.sv
`timescale 1ns/1ps

module instr_classifier (
    input  logic [isa_pkg::word_width-1:0]     instr,
    output issue_pkg::unit_t                   unit,
    output issue_pkg::alu_op_t                 alu_op,
    output logic                               uses_rs,
    output logic                               uses_rt,
    output logic [isa_pkg::reg_addr_width-1:0] dest,
    output logic                               writes_reg,
    output logic [isa_pkg::word_width-1:0]     imm
);

    import isa_pkg::*;
    import issue_pkg::*;

    opcode_t                   op;
    funct_t                    fn;
    logic [reg_addr_width-1:0] rt_field;
    logic [reg_addr_width-1:0] rd_field;
    logic [imm_width-1:0]      imm_field;
    logic                      known;

    assign op        = opcode_t'(instr[word_width-1 -: op_width]);
    assign fn        = funct_t'(instr[funct_width-1:0]);
    assign rt_field  = instr[rt_lsb +: reg_addr_width];
    assign rd_field  = instr[rd_lsb +: reg_addr_width];
    assign imm_field = instr[imm_width-1:0];

    // Unit and ALU operation per opcode and funct
    always_comb begin
        unit   = unit_none;
        alu_op = alu_add;
        case (op)
            op_special: begin
                case (fn)
                    fn_addu: unit = unit_alu;
                    fn_subu: begin
                        unit   = unit_alu;
                        alu_op = alu_sub;
                    end
                    fn_and: begin
                        unit   = unit_alu;
                        alu_op = alu_and;
                    end
                    fn_or: begin
                        unit   = unit_alu;
                        alu_op = alu_or;
                    end
                    fn_slt: begin
                        unit   = unit_alu;
                        alu_op = alu_slt;
                    end
                    fn_mult: unit = unit_mul;
                    default: unit = unit_none;
                endcase
            end
            op_addiu: unit = unit_alu;
            op_slti: begin
                unit   = unit_alu;
                alu_op = alu_slt;
            end
            op_andi: begin
                unit   = unit_alu;
                alu_op = alu_and;
            end
            op_ori: begin
                unit   = unit_alu;
                alu_op = alu_or;
            end
            op_lui: begin
                unit   = unit_alu;
                alu_op = alu_lui;
            end
            op_lw, op_sw: unit = unit_mem;
            default: unit = unit_none;
        endcase
    end

    // Register use, all off for unrecognised words
    assign known      = (unit != unit_none);
    assign uses_rs    = known && (op != op_lui);
    assign uses_rt    = known && (op == op_special || op == op_sw);
    assign writes_reg = known && (op != op_sw);
    assign dest       = !writes_reg ? reg_zero : (op == op_special) ? rd_field : rt_field;

    // Immediate extension
    always_comb begin
        case (op)
            op_andi, op_ori: imm = {{(word_width-imm_width){1'b0}}, imm_field};
            op_lui:          imm = {imm_field, {(word_width-imm_width){1'b0}}};
            default:         imm = {{(word_width-imm_width){imm_field[imm_width-1]}}, imm_field};
        endcase
    end

endmodule

//--- src/issue_controller.sv
`timescale 1ns/1ps

module issue_controller (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               valid,
    input  issue_pkg::unit_t                   unit,
    input  issue_pkg::alu_op_t                 alu_op,
    input  logic                               uses_rs,
    input  logic                               uses_rt,
    input  logic [isa_pkg::reg_addr_width-1:0] dest,
    input  logic                               writes_reg,
    input  logic [isa_pkg::word_width-1:0]     imm,
    input  logic                               rs_pending,
    input  logic                               rt_pending,
    input  logic [isa_pkg::word_width-1:0]     rs_data,
    input  logic [isa_pkg::word_width-1:0]     rt_data,
    output logic                               stall,
    output logic                               set_en,
    output logic [isa_pkg::reg_addr_width-1:0] set_addr,
    output logic                               ex_alu_oper,
    output logic                               ex_mem_oper,
    output logic                               ex_mul_oper,
    output issue_pkg::alu_op_t                 ex_alu_op,
    output logic [isa_pkg::word_width-1:0]     ex_rega,
    output logic [isa_pkg::word_width-1:0]     ex_regb,
    output logic [isa_pkg::word_width-1:0]     ex_imm,
    output logic [isa_pkg::reg_addr_width-1:0] ex_dest,
    output logic                               ex_writereg
);

    import isa_pkg::*;
    import issue_pkg::*;

    logic hazard;
    logic accept;

    // RAW hazard on a source that is actually read
    assign hazard = (uses_rs && rs_pending) || (uses_rt && rt_pending);
    assign stall  = valid && hazard;
    assign accept = valid && !hazard;

    // Mark the destination busy on issue, register 0 excluded
    assign set_en   = accept && writes_reg && (unit != unit_none) && (dest != reg_zero);
    assign set_addr = dest;

    // Unit pulses last one cycle and follow acceptance by one cycle
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ex_alu_oper <= 1'b0;
            ex_mem_oper <= 1'b0;
            ex_mul_oper <= 1'b0;
            ex_writereg <= 1'b0;
        end else begin
            ex_alu_oper <= accept && (unit == unit_alu);
            ex_mem_oper <= accept && (unit == unit_mem);
            ex_mul_oper <= accept && (unit == unit_mul);
            ex_writereg <= set_en;
        end
    end

    // Operand and control payload, held until the next acceptance
    always_ff @(posedge clock) begin
        if (accept) begin
            ex_alu_op <= alu_op;
            ex_rega   <= rs_data;
            ex_regb   <= rt_data;
            ex_imm    <= imm;
            ex_dest   <= dest;
        end
    end

endmodule

//--- src/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               id_valid,
    input  logic [isa_pkg::word_width-1:0]     id_instr,
    output logic                               id_stall,
    input  logic                               wb_valid,
    input  logic [isa_pkg::reg_addr_width-1:0] wb_addr,
    input  logic [isa_pkg::word_width-1:0]     wb_data,
    output logic                               ex_alu_oper,
    output logic                               ex_mem_oper,
    output logic                               ex_mul_oper,
    output issue_pkg::alu_op_t                 ex_alu_op,
    output logic [isa_pkg::word_width-1:0]     ex_rega,
    output logic [isa_pkg::word_width-1:0]     ex_regb,
    output logic [isa_pkg::word_width-1:0]     ex_imm,
    output logic [isa_pkg::reg_addr_width-1:0] ex_dest,
    output logic                               ex_writereg
);

    import isa_pkg::*;
    import issue_pkg::*;

    // Source fields straight from the decode word
    logic [reg_addr_width-1:0] rs_addr;
    logic [reg_addr_width-1:0] rt_addr;

    logic [word_width-1:0]     rs_data;
    logic [word_width-1:0]     rt_data;
    logic                      rs_pending;
    logic                      rt_pending;
    logic                      set_en;
    logic [reg_addr_width-1:0] set_addr;

    // Classifier results
    unit_t                     unit;
    alu_op_t                   alu_op;
    logic                      uses_rs;
    logic                      uses_rt;
    logic [reg_addr_width-1:0] dest;
    logic                      writes_reg;
    logic [word_width-1:0]     imm;

    assign rs_addr = id_instr[rs_lsb +: reg_addr_width];
    assign rt_addr = id_instr[rt_lsb +: reg_addr_width];

    register_file register_file_i (
        .clock      (clock),
        .reset      (reset),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .write_en   (wb_valid),
        .write_addr (wb_addr),
        .write_data (wb_data)
    );

    scoreboard scoreboard_i (
        .clock      (clock),
        .reset      (reset),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rs_pending (rs_pending),
        .rt_pending (rt_pending),
        .set_en     (set_en),
        .set_addr   (set_addr),
        .clear_en   (wb_valid),
        .clear_addr (wb_addr)
    );

    instr_classifier instr_classifier_i (
        .instr      (id_instr),
        .unit       (unit),
        .alu_op     (alu_op),
        .uses_rs    (uses_rs),
        .uses_rt    (uses_rt),
        .dest       (dest),
        .writes_reg (writes_reg),
        .imm        (imm)
    );

    issue_controller issue_controller_i (
        .clock       (clock),
        .reset       (reset),
        .valid       (id_valid),
        .unit        (unit),
        .alu_op      (alu_op),
        .uses_rs     (uses_rs),
        .uses_rt     (uses_rt),
        .dest        (dest),
        .writes_reg  (writes_reg),
        .imm         (imm),
        .rs_pending  (rs_pending),
        .rt_pending  (rt_pending),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .stall       (id_stall),
        .set_en      (set_en),
        .set_addr    (set_addr),
        .ex_alu_oper (ex_alu_oper),
        .ex_mem_oper (ex_mem_oper),
        .ex_mul_oper (ex_mul_oper),
        .ex_alu_op   (ex_alu_op),
        .ex_rega     (ex_rega),
        .ex_regb     (ex_regb),
        .ex_imm      (ex_imm),
        .ex_dest     (ex_dest),
        .ex_writereg (ex_writereg)
    );

endmodule

//--- tb/issue_stage_tb.sv
`timescale 1ns/1ps

module issue_stage_tb;

    import isa_pkg::*;
    import issue_pkg::*;

    localparam int num_instrs   = 400;
    localparam int clock_period = 10;

    logic        clock = 1'b0;
    logic        reset;
    logic        id_valid;
    logic [31:0] id_instr;
    logic        id_stall;
    logic        wb_valid;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        ex_alu_oper;
    logic        ex_mem_oper;
    logic        ex_mul_oper;
    alu_op_t     ex_alu_op;
    logic [31:0] ex_rega;
    logic [31:0] ex_regb;
    logic [31:0] ex_imm;
    logic [4:0]  ex_dest;
    logic        ex_writereg;

    logic [31:0] lfsr_state;

    // Shadow model of the register file and scoreboard
    logic [31:0] shadow_regs [0:31];
    logic [31:0] shadow_pending;

    // Expected outputs for the current cycle, and for the one after the next edge
    logic        exp_stall;
    logic [2:0]  exp_pulses;
    logic        exp_writereg;
    alu_op_t     exp_alu_op;
    logic [31:0] exp_rega;
    logic [31:0] exp_regb;
    logic [31:0] exp_imm;
    logic [4:0]  exp_dest;
    logic [2:0]  nxt_pulses;
    logic        nxt_writereg;
    alu_op_t     nxt_alu_op;
    logic [31:0] nxt_rega;
    logic [31:0] nxt_regb;
    logic [31:0] nxt_imm;
    logic [4:0]  nxt_dest;

    issue_stage issue_stage_i (
        .clock       (clock),
        .reset       (reset),
        .id_valid    (id_valid),
        .id_instr    (id_instr),
        .id_stall    (id_stall),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .ex_alu_oper (ex_alu_oper),
        .ex_mem_oper (ex_mem_oper),
        .ex_mul_oper (ex_mul_oper),
        .ex_alu_op   (ex_alu_op),
        .ex_rega     (ex_rega),
        .ex_regb     (ex_regb),
        .ex_imm      (ex_imm),
        .ex_dest     (ex_dest),
        .ex_writereg (ex_writereg)
    );

    always #(clock_period / 2) clock = ~clock;

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first failing check");
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] next_bits(input int count);
        logic [31:0] result;
        result = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            result = {result[30:0], lfsr_state[0]};
        end
        return result;
    endfunction

    // Registers limited to 0..7 so hazards come often
    function automatic logic [31:0] make_instr();
        logic [3:0]  sel;
        logic [2:0]  fsel;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        sel  = 4'(next_bits(4));
        fsel = 3'(next_bits(3));
        rs   = 5'(next_bits(3));
        rt   = 5'(next_bits(3));
        rd   = 5'(next_bits(3));
        imm  = 16'(next_bits(16));
        case (fsel)
            3'd0: fn = fn_addu;
            3'd1: fn = fn_subu;
            3'd2: fn = fn_and;
            3'd3: fn = fn_or;
            3'd4: fn = fn_slt;
            3'd5: fn = fn_mult;
            default: fn = 6'h00;
        endcase
        case (sel)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd15: op = op_special;
            4'd4: op = op_addiu;
            4'd5: op = op_slti;
            4'd6: op = op_andi;
            4'd7: op = op_ori;
            4'd8: op = op_lui;
            4'd9, 4'd10: op = op_lw;
            4'd11, 4'd12: op = op_sw;
            4'd13: op = 6'h3f;
            default: op = 6'h02;
        endcase
        if (op == op_special) begin
            return {op, rs, rt, rd, 5'd0, fn};
        end else begin
            return {op, rs, rt, imm};
        end
    endfunction

    // Per-opcode table of unit, operation, register use and immediate
    task automatic classify(input logic [31:0] instr, output unit_t unit,
                            output alu_op_t alu_op, output logic uses_rs,
                            output logic uses_rt, output logic writes,
                            output logic [4:0] dest, output logic [31:0] imm);
        logic [5:0] op;
        logic [5:0] fn;
        op      = instr[31:26];
        fn      = instr[5:0];
        unit    = unit_alu;
        alu_op  = alu_add;
        uses_rs = 1'b1;
        uses_rt = 1'b0;
        writes  = 1'b1;
        dest    = instr[20:16];
        imm     = {{16{instr[15]}}, instr[15:0]};
        case (op)
            op_special: begin
                uses_rt = 1'b1;
                dest    = instr[15:11];
                case (fn)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    fn_mult: unit = unit_mul;
                    default: unit = unit_none;
                endcase
            end
            op_addiu: alu_op = alu_add;
            op_slti:  alu_op = alu_slt;
            op_andi: begin
                alu_op = alu_and;
                imm    = {16'h0000, instr[15:0]};
            end
            op_ori: begin
                alu_op = alu_or;
                imm    = {16'h0000, instr[15:0]};
            end
            op_lui: begin
                alu_op  = alu_lui;
                uses_rs = 1'b0;
                imm     = {instr[15:0], 16'h0000};
            end
            op_lw: unit = unit_mem;
            op_sw: begin
                unit    = unit_mem;
                uses_rt = 1'b1;
                writes  = 1'b0;
                dest    = 5'd0;
            end
            default: unit = unit_none;
        endcase
        // Unrecognised words touch no register
        if (unit == unit_none) begin
            uses_rs = 1'b0;
            uses_rt = 1'b0;
            writes  = 1'b0;
            dest    = 5'd0;
        end
    endtask

    // Commit the last edge to the model, then drive and predict the next cycle
    task automatic step(input logic valid, input logic [31:0] instr);
        unit_t       unit;
        alu_op_t     alu_op;
        logic        uses_rs;
        logic        uses_rt;
        logic        writes;
        logic [4:0]  dest;
        logic [31:0] imm;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic        accept;
        @(negedge clock);
        // Clear before set so a same-cycle set wins
        if (wb_valid && wb_addr != 5'd0) begin
            shadow_regs[wb_addr]    = wb_data;
            shadow_pending[wb_addr] = 1'b0;
        end
        if (nxt_writereg) begin
            shadow_pending[nxt_dest] = 1'b1;
        end
        exp_pulses   = nxt_pulses;
        exp_writereg = nxt_writereg;
        exp_alu_op   = nxt_alu_op;
        exp_rega     = nxt_rega;
        exp_regb     = nxt_regb;
        exp_imm      = nxt_imm;
        exp_dest     = nxt_dest;

        rs = instr[25:21];
        rt = instr[20:16];
        classify(instr, unit, alu_op, uses_rs, uses_rt, writes, dest, imm);
        exp_stall    = valid && ((uses_rs && shadow_pending[rs]) || (uses_rt && shadow_pending[rt]));
        accept       = valid && !exp_stall;
        nxt_pulses   = accept ? {unit == unit_alu, unit == unit_mem, unit == unit_mul} : 3'b000;
        nxt_writereg = accept && writes && dest != 5'd0;
        nxt_alu_op   = alu_op;
        nxt_dest     = dest;
        nxt_rega     = shadow_regs[rs];
        nxt_regb     = shadow_regs[rt];
        nxt_imm      = imm;
        id_valid     = valid;
        id_instr     = instr;

        // A stalled word gets its blocking register written back
        if (exp_stall) begin
            wb_valid = 1'b1;
            wb_addr  = (uses_rs && shadow_pending[rs]) ? rs : rt;
        end else begin
            wb_valid = (next_bits(2) == 32'd0);
            wb_addr  = 5'(next_bits(3));
        end
        wb_data = next_bits(32);
    endtask

    stall_check: assert property (@(posedge clock) disable iff (!reset) id_stall == exp_stall)
        else report_failure("id_stall differs from the scoreboard model");
    pulse_check: assert property (@(posedge clock) disable iff (!reset)
        {ex_alu_oper, ex_mem_oper, ex_mul_oper} == exp_pulses)
        else report_failure($sformatf("unit pulses %b, expected %b",
            $sampled({ex_alu_oper, ex_mem_oper, ex_mul_oper}), $sampled(exp_pulses)));
    onehot_check: assert property (@(posedge clock) disable iff (!reset)
        $onehot0({ex_alu_oper, ex_mem_oper, ex_mul_oper}))
        else report_failure("more than one unit pulse high");
    writereg_check: assert property (@(posedge clock) disable iff (!reset)
        ex_writereg == exp_writereg)
        else report_failure("ex_writereg differs from the destination rule");
    alu_op_check: assert property (@(posedge clock) disable iff (!reset)
        (exp_pulses[2] || exp_pulses[1]) |-> ex_alu_op == exp_alu_op)
        else report_failure("ex_alu_op differs from the operation of the opcode");
    operand_check: assert property (@(posedge clock) disable iff (!reset)
        (|exp_pulses) |-> (ex_rega == exp_rega && ex_regb == exp_regb))
        else report_failure("issued operands differ from the shadow registers");
    imm_check: assert property (@(posedge clock) disable iff (!reset)
        (|exp_pulses) |-> ex_imm == exp_imm)
        else report_failure("ex_imm differs from the extension rule");
    dest_check: assert property (@(posedge clock) disable iff (!reset)
        (|exp_pulses) |-> ex_dest == exp_dest)
        else report_failure("ex_dest differs from the destination rule");

    initial begin
        #(num_instrs * 40 * clock_period);
        $display("Watchdog expired after %0d cycles, the run hung", num_instrs * 40);
        $display("Simulation finished: FAIL");
        $fatal(1, "Watchdog timeout");
    end

    initial begin
        int          accepted;
        logic        valid;
        logic [31:0] instr;
        reset          = 1'b0;
        id_valid       = 1'b0;
        id_instr       = '0;
        wb_valid       = 1'b0;
        wb_addr        = '0;
        wb_data        = '0;
        lfsr_state     = 32'h001c_c4db;
        shadow_pending = '0;
        for (int i = 0; i < 32; i++) begin
            shadow_regs[i] = '0;
        end
        exp_stall    = 1'b0;
        exp_pulses   = '0;
        exp_writereg = 1'b0;
        nxt_pulses   = '0;
        nxt_writereg = 1'b0;
        nxt_alu_op   = alu_add;
        nxt_dest     = '0;
        accepted     = 0;
        valid        = 1'b0;
        instr        = '0;

        repeat (10) @(negedge clock);
        reset = 1'b1;

        // Idle cycles after reset with writebacks only
        repeat (6) step(1'b0, 32'h0);

        while (accepted < num_instrs) begin
            // Decode holds the word while stalled
            if (!exp_stall) begin
                instr = make_instr();
                valid = (next_bits(2) != 32'd0);
            end
            step(valid, instr);
            if (valid && !exp_stall) begin
                accepted++;
            end
        end
        repeat (3) step(1'b0, 32'h0);
        @(negedge clock);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- issue_stage.f
src/isa_pkg.sv
src/issue_pkg.sv
src/register_file.sv
src/scoreboard.sv
src/instr_classifier.sv
src/issue_controller.sv
src/issue_stage.sv
tb/issue_stage_tb.sv
